// File: files.f
hw/id_pkg.sv
hw/inst_decoder.sv
hw/gpr_file.sv
hw/hazard_check.sv
hw/branch_unit.sv
hw/id_stage.sv
verif/tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/tb_id_stage.sv
// rv64i decode stage testbench for decode, stall, back-pressure, branch and squash
`default_nettype none

module tb_id_stage;
  timeunit 1ns;
  timeprecision 1ps;

  import id_pkg::*;

  localparam int test_cycles = 11 + 36 * 2 + 38 * 3 + 34; // reset, gpr writes, issues, held cycles

  logic                   i_clk, i_arst_n, i_fs_to_ds_valid, i_es_allowin, i_wb_wen;
  logic [inst_wd-1:0]     i_fs_inst;
  logic [xlen-1:0]        i_fs_pc, i_wb_wdata;
  logic [gpr_addr_wd-1:0] i_wb_waddr, i_es_rd, i_ms_rd, i_ws_rd;
  logic                   o_ds_allowin, o_br_sel, o_ds_to_es_valid, o_gpr_wen, o_alu_src1_pc;
  logic                   o_alu_word, o_mem_ren, o_mem_wen, o_invalid_inst;
  logic [xlen-1:0]        o_br_target, o_rs1_data, o_rs2_data, o_imm, o_pc;
  logic [gpr_addr_wd-1:0] o_rd;
  alu_op_e                o_alu_op;
  alu_src2_e              o_alu_src2_sel;
  logic [2:0]             o_mem_op;

  logic [xlen-1:0] shadow [32]; // model register file

  id_stage i_id_stage (.*);

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  initial begin
    #(test_cycles * 15);
    $display("watchdog expired, the run did not finish in time");
    $display("TEST RESULT: FAIL");
    $fatal(1);
  end

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [63:0] data);
    @(posedge i_clk);
    i_wb_wen   <= 1'b1;
    i_wb_waddr <= addr;
    i_wb_wdata <= data;
    @(posedge i_clk);
    i_wb_wen <= 1'b0;
    if (addr != 5'd0) shadow[addr] = data;
  endtask

  // present one instruction and return at its accepting edge
  task automatic issue(input logic [31:0] inst, input logic [63:0] pc, input bit hold);
    int n;
    n = 0;
    @(posedge i_clk);
    i_fs_to_ds_valid <= 1'b1;
    i_fs_inst        <= inst;
    i_fs_pc          <= pc;
    @(negedge i_clk);
    while (!o_ds_allowin) begin
      n++;
      if (n == 50) begin
        $display("decode slot never accepted the instruction");
        $display("TEST RESULT: FAIL");
        $fatal(1);
      end
      @(negedge i_clk);
    end
    @(posedge i_clk);
    if (!hold) i_fs_to_ds_valid <= 1'b0;
  endtask

  function automatic logic [63:0] sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic logic br_model(input logic [2:0] f3, input logic [63:0] a,
                                    input logic [63:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
  endfunction

  task automatic check_branch(input string name, input logic [31:0] inst, input logic [63:0] pc);
    logic [63:0] a, b, tgt;
    logic        sel, link;
    a = shadow[inst[19:15]];
    b = shadow[inst[24:20]];
    if (inst[6:0] == opc_jal) begin
      sel  = 1'b1;
      link = 1'b1;
      tgt  = pc + {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    end else if (inst[6:0] == opc_jalr) begin
      sel  = 1'b1;
      link = 1'b1;
      tgt  = (a + sext12(inst[31:20])) & ~64'd1;
    end else begin
      sel  = br_model(inst[14:12], a, b);
      link = 1'b0;
      tgt  = pc + {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    end
    issue(inst, pc, 1'b0);
    @(negedge i_clk);
    check({name, " br_sel"}, 64'(sel), 64'(o_br_sel));
    check({name, " target"}, tgt, o_br_target);
    check({name, " src1_pc"}, 64'(link), 64'(o_alu_src1_pc));
  endtask

  initial begin
    int          kind;
    logic [4:0]  rd, rs1, rs2;
    logic [11:0] imm;
    logic [19:0] u20;
    logic [31:0] inst;
    logic [63:0] e_imm;
    logic [3:0]  e_op;
    alu_src2_e   e_src2;
    logic        e_gwen, e_ren, e_mwen, e_word;
    void'($urandom(32'hf43c));
    i_arst_n = 1'b0;
    i_fs_to_ds_valid = 1'b0;
    i_fs_inst = '0;
    i_fs_pc = '0;
    i_es_allowin = 1'b1;
    i_wb_wen = 1'b0;
    i_wb_waddr = '0;
    i_wb_wdata = '0;
    i_es_rd = '0;
    i_ms_rd = '0;
    i_ws_rd = '0;
    for (int i = 0; i < 32; i++) shadow[i] = '0;

    repeat (10) begin
      @(negedge i_clk);
      check("reset valid", 64'd0, 64'(o_ds_to_es_valid));
      check("reset br_sel", 64'd0, 64'(o_br_sel));
      check("reset allowin", 64'd1, 64'(o_ds_allowin));
    end
    @(posedge i_clk);
    i_arst_n <= 1'b1;
    @(negedge i_clk);
    check("post reset allowin", 64'd1, 64'(o_ds_allowin));

    for (int r = 1; r < 32; r++) write_reg(5'(r), {$urandom, $urandom});

    for (int t = 0; t < 24; t++) begin
      kind = $urandom % 7;
      rd = 5'($urandom);
      rs1 = 5'($urandom);
      rs2 = 5'($urandom);
      imm = 12'($urandom);
      u20 = 20'($urandom);
      e_imm = sext12(imm);
      e_op = 4'(alu_add);
      e_src2 = src2_imm;
      e_gwen = (rd != 5'd0);
      e_ren = 1'b0;
      e_mwen = 1'b0;
      e_word = 1'b0;
      case (kind)
        0: inst = {imm, rs1, 3'd0, rd, opc_op_imm};
        1: inst = {f7_base, rs2, rs1, 3'd0, rd, opc_op};
        2: inst = {f7_alt, rs2, rs1, 3'd0, rd, opc_op};
        3: inst = {imm, rs1, 3'd3, rd, opc_load};
        4: inst = {imm[11:5], rs2, rs1, 3'd3, imm[4:0], opc_store};
        5: inst = {u20, rd, opc_lui};
        default: inst = {imm, rs1, 3'd0, rd, opc_op_imm_32};
      endcase
      if (kind == 1 || kind == 2) begin
        e_imm = '0;
        e_src2 = src2_rs2;
      end
      if (kind == 2) e_op = 4'(alu_sub);
      if (kind == 3) e_ren = 1'b1;
      if (kind == 4) begin
        e_gwen = 1'b0;
        e_mwen = 1'b1;
      end
      if (kind == 5) begin
        e_imm = {{32{u20[19]}}, u20, 12'd0};
        e_op = 4'(alu_pass_b);
      end
      if (kind == 6) e_word = 1'b1;
      issue(inst, 64'h1000 + 64'(t * 4), 1'b0);
      @(negedge i_clk);
      check("decode rd", 64'(inst[11:7]), 64'(o_rd));
      check("decode imm", e_imm, o_imm);
      check("decode alu_op", 64'(e_op), 64'(o_alu_op));
      check("decode gpr_wen", 64'(e_gwen), 64'(o_gpr_wen));
      check("decode mem_ren", 64'(e_ren), 64'(o_mem_ren));
      check("decode mem_wen", 64'(e_mwen), 64'(o_mem_wen));
      check("decode src1_pc", 64'd0, 64'(o_alu_src1_pc));
      check("decode src2_sel", 64'(e_src2), 64'(o_alu_src2_sel));
      check("decode alu_word", 64'(e_word), 64'(o_alu_word));
      if (kind == 3 || kind == 4) check("decode mem_op", 64'd3, 64'(o_mem_op)); // doubleword
      check("decode rs1 data", shadow[inst[19:15]], o_rs1_data);
      check("decode rs2 data", shadow[inst[24:20]], o_rs2_data);
    end
    issue({25'd0, 7'h7f}, 64'h2000, 1'b0);
    @(negedge i_clk);
    check("illegal opcode", 64'd1, 64'(o_invalid_inst));

    // hazard held by each later stage in turn
    for (int p = 0; p < num_pend; p++) begin
      @(posedge i_clk);
      case (p)
        0: i_es_rd <= 5'd5;
        1: i_ms_rd <= 5'd5;
        default: i_ws_rd <= 5'd6; // rs2 side
      endcase
      issue({f7_base, 5'd6, 5'd5, 3'd0, 5'd3, opc_op}, 64'h3000 + 64'(p * 4), 1'b0);
      repeat (5) begin
        @(negedge i_clk);
        check("stall valid", 64'd0, 64'(o_ds_to_es_valid));
        check("stall allowin", 64'd0, 64'(o_ds_allowin));
      end
      @(posedge i_clk);
      i_es_rd <= 5'd0;
      i_ms_rd <= 5'd0;
      i_ws_rd <= 5'd0;
      @(negedge i_clk);
      check("stall release", 64'd1, 64'(o_ds_to_es_valid));
    end

    write_reg(5'd0, 64'h0123_4567_89ab_cdef);
    // pending x0 against a used x0 source and a match on the unused rs2 field of addi
    @(posedge i_clk);
    i_ws_rd <= 5'd7;
    issue({12'h007, 5'd0, 3'd0, 5'd3, opc_op_imm}, 64'h3010, 1'b0);
    @(negedge i_clk);
    check("no false stall", 64'd1, 64'(o_ds_to_es_valid));
    check("x0 read", 64'd0, o_rs1_data);
    @(posedge i_clk);
    i_ws_rd <= 5'd0;

    // back-pressure with the next instruction waiting at fetch
    i_es_allowin <= 1'b0;
    issue({12'h123, 5'd9, 3'd0, 5'd4, opc_op_imm}, 64'h4000, 1'b1);
    i_fs_inst <= {12'h456, 5'd10, 3'd0, 5'd11, opc_op_imm};
    i_fs_pc   <= 64'h4004;
    repeat (5) begin
      @(negedge i_clk);
      check("hold valid", 64'd1, 64'(o_ds_to_es_valid));
      check("hold imm", 64'h123, o_imm);
      check("hold rs1 data", shadow[9], o_rs1_data);
      check("hold pc", 64'h4000, o_pc);
      check("hold rd", 64'd4, 64'(o_rd));
      check("hold gpr_wen", 64'd1, 64'(o_gpr_wen));
      check("hold allowin", 64'd0, 64'(o_ds_allowin));
    end
    @(posedge i_clk);
    i_es_allowin     <= 1'b1;
    i_fs_to_ds_valid <= 1'b0;

    write_reg(5'd1, 64'd10);
    write_reg(5'd2, 64'd10);
    write_reg(5'd3, 64'hffff_ffff_ffff_fffb);
    write_reg(5'd4, 64'd3);
    check_branch("beq", enc_b(13'd16, 5'd2, 5'd1, f3_beq), 64'h5000);
    check_branch("bne", enc_b(13'd16, 5'd2, 5'd1, f3_bne), 64'h5004);
    check_branch("blt", enc_b(13'h1ff0, 5'd4, 5'd3, f3_blt), 64'h5008);
    check_branch("bgeu", enc_b(13'd40, 5'd4, 5'd3, f3_bgeu), 64'h500c);
    check_branch("jal", {1'b0, 10'h080, 1'b0, 8'd0, 5'd0, opc_jal}, 64'h5010);
    check_branch("jalr", {12'd6, 5'd4, 3'd0, 5'd0, opc_jalr}, 64'h5014);

    // taken beq followed by a fall-through fetch to drop
    issue(enc_b(13'd16, 5'd2, 5'd1, f3_beq), 64'h6000, 1'b1);
    i_fs_inst <= {12'h001, 5'd1, 3'd0, 5'd8, opc_op_imm};
    i_fs_pc   <= 64'h6004;
    @(negedge i_clk);
    check("squash br_sel", 64'd1, 64'(o_br_sel));
    @(posedge i_clk);
    i_fs_to_ds_valid <= 1'b0;
    @(negedge i_clk);
    check("squashed valid", 64'd0, 64'(o_ds_to_es_valid));

    // same branch again, now followed by a fetch at its target
    issue(enc_b(13'd16, 5'd2, 5'd1, f3_beq), 64'h6008, 1'b1);
    i_fs_inst <= {12'h001, 5'd1, 3'd0, 5'd8, opc_op_imm};
    i_fs_pc   <= 64'h6018;
    @(posedge i_clk);
    i_fs_to_ds_valid <= 1'b0;
    @(negedge i_clk);
    check("target valid", 64'd1, 64'(o_ds_to_es_valid));
    check("target pc", 64'h6018, o_pc);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/id_stage.sv
// decode stage of the rv64i pipeline: slot, stall control, gpr read and branch
`default_nettype none

module id_stage (
  input  logic                            i_clk,
  input  logic                            i_arst_n,
  // fetch
  input  logic                            i_fs_to_ds_valid,
  input  logic [id_pkg::inst_wd-1:0]      i_fs_inst,
  input  logic [id_pkg::xlen-1:0]         i_fs_pc,
  output logic                            o_ds_allowin,
  output logic                            o_br_sel,
  output logic [id_pkg::xlen-1:0]         o_br_target,
  // execute
  input  logic                            i_es_allowin,
  output logic                            o_ds_to_es_valid,
  output logic [id_pkg::xlen-1:0]         o_rs1_data,
  output logic [id_pkg::xlen-1:0]         o_rs2_data,
  output logic [id_pkg::xlen-1:0]         o_imm,
  output logic [id_pkg::xlen-1:0]         o_pc,
  output logic [id_pkg::gpr_addr_wd-1:0]  o_rd,
  output logic                            o_gpr_wen,
  output id_pkg::alu_op_e                 o_alu_op,
  output logic                            o_alu_src1_pc,
  output id_pkg::alu_src2_e               o_alu_src2_sel,
  output logic                            o_alu_word,
  output logic                            o_mem_ren,
  output logic                            o_mem_wen,
  output logic [2:0]                      o_mem_op,
  output logic                            o_invalid_inst,
  // write back
  input  logic                            i_wb_wen,
  input  logic [id_pkg::gpr_addr_wd-1:0]  i_wb_waddr,
  input  logic [id_pkg::xlen-1:0]         i_wb_wdata,
  // pending rd of es, ms, ws, zero when idle
  input  logic [id_pkg::gpr_addr_wd-1:0]  i_es_rd,
  input  logic [id_pkg::gpr_addr_wd-1:0]  i_ms_rd,
  input  logic [id_pkg::gpr_addr_wd-1:0]  i_ws_rd
);

  import id_pkg::*;

  logic                   ds_valid;
  inst_u                  ds_inst;
  logic [xlen-1:0]        ds_pc;
  logic [gpr_addr_wd-1:0] rs1, rs2;
  logic                   rs1_used, rs2_used;
  br_op_e                 br_op;
  logic                   br_taken;
  logic                   is_jalr;
  logic [gpr_addr_wd-1:0] pend_rd [num_pend];
  logic [num_pend-1:0]    conflict;
  logic                   stall;
  logic                   squash;

  assign stall            = |conflict;
  assign o_ds_allowin     = !ds_valid || (!stall && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && !stall;
  assign o_br_sel         = ds_valid && br_taken;
  assign squash           = o_br_sel && (i_fs_pc != o_br_target); // wrong-path fetch

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid && !squash;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_inst <= i_fs_inst;
      ds_pc   <= i_fs_pc;
    end
  end

  assign o_pc    = ds_pc;
  assign is_jalr = (ds_inst.i.opcode == opc_jalr);

  inst_decoder u_decoder (
    .i_inst         (ds_inst),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (o_rd),
    .o_rs1_used     (rs1_used),
    .o_rs2_used     (rs2_used),
    .o_imm          (o_imm),
    .o_alu_op       (o_alu_op),
    .o_alu_src1_pc  (o_alu_src1_pc),
    .o_alu_src2_sel (o_alu_src2_sel),
    .o_alu_word     (o_alu_word),
    .o_br_op        (br_op),
    .o_gpr_wen      (o_gpr_wen),
    .o_mem_ren      (o_mem_ren),
    .o_mem_wen      (o_mem_wen),
    .o_mem_op       (o_mem_op),
    .o_invalid_inst (o_invalid_inst)
  );

  gpr_file u_gprs (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wen    (i_wb_wen),
    .i_waddr  (i_wb_waddr),
    .i_wdata  (i_wb_wdata),
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data)
  );

  branch_unit u_bru (
    .i_br_op     (br_op),
    .i_rs1_data  (o_rs1_data),
    .i_rs2_data  (o_rs2_data),
    .i_pc        (ds_pc),
    .i_imm       (o_imm),
    .i_is_jalr   (is_jalr),
    .o_br_sel    (br_taken),
    .o_br_target (o_br_target)
  );

  assign pend_rd[0] = i_es_rd;
  assign pend_rd[1] = i_ms_rd;
  assign pend_rd[2] = i_ws_rd;

  for (genvar g = 0; g < num_pend; g++) begin : g_hazard
    hazard_check u_hazard (
      .i_pend_rd  (pend_rd[g]),
      .i_rs1      (rs1),
      .i_rs2      (rs2),
      .i_rs1_used (rs1_used),
      .i_rs2_used (rs2_used),
      .o_conflict (conflict[g])
    );
  end

endmodule

`default_nettype wire

// File: hw/branch_unit.sv
// branch unit: resolves branch condition and jump target for fetch redirect
`default_nettype none

module branch_unit (
  input  id_pkg::br_op_e               i_br_op,
  input  logic [id_pkg::xlen-1:0]      i_rs1_data,
  input  logic [id_pkg::xlen-1:0]      i_rs2_data,
  input  logic [id_pkg::xlen-1:0]      i_pc,
  input  logic [id_pkg::xlen-1:0]      i_imm,
  input  logic                         i_is_jalr,
  output logic                         o_br_sel,
  output logic [id_pkg::xlen-1:0]      o_br_target
);

  import id_pkg::*;

  logic            eq;
  logic            lt_s;
  logic            lt_u;
  logic [xlen-1:0] jalr_sum;

  assign eq   = (i_rs1_data == i_rs2_data);
  assign lt_s = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign lt_u = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_br_op)
      br_eq:   o_br_sel = eq;
      br_ne:   o_br_sel = !eq;
      br_lt:   o_br_sel = lt_s;
      br_ge:   o_br_sel = !lt_s;
      br_ltu:  o_br_sel = lt_u;
      br_geu:  o_br_sel = !lt_u;
      br_jump: o_br_sel = 1'b1;
      default: o_br_sel = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1_data + i_imm;

  // jalr clears bit 0 of the sum
  assign o_br_target = i_is_jalr ? {jalr_sum[xlen-1:1], 1'b0} : i_pc + i_imm;

endmodule

`default_nettype wire

// File: hw/hazard_check.sv
// raw hazard check of one pending destination register against the used sources
`default_nettype none

module hazard_check (
  input  logic [id_pkg::gpr_addr_wd-1:0]  i_pend_rd,
  input  logic [id_pkg::gpr_addr_wd-1:0]  i_rs1,
  input  logic [id_pkg::gpr_addr_wd-1:0]  i_rs2,
  input  logic                            i_rs1_used,
  input  logic                            i_rs2_used,
  output logic                            o_conflict
);

  logic hit_rs1;
  logic hit_rs2;

  // unused source fields may hold immediate bits
  assign hit_rs1 = i_rs1_used && (i_pend_rd == i_rs1);
  assign hit_rs2 = i_rs2_used && (i_pend_rd == i_rs2);

  assign o_conflict = (i_pend_rd != '0) && (hit_rs1 || hit_rs2); // x0 is no dependency

endmodule

`default_nettype wire

// File: hw/gpr_file.sv
// general register file, 2 async read ports and 1 sync write port, x0 hardwired
`default_nettype none

module gpr_file (
  input  logic                            i_clk,
  input  logic                            i_arst_n,
  input  logic [id_pkg::gpr_addr_wd-1:0]  i_raddr1,
  input  logic [id_pkg::gpr_addr_wd-1:0]  i_raddr2,
  input  logic                            i_wen,
  input  logic [id_pkg::gpr_addr_wd-1:0]  i_waddr,
  input  logic [id_pkg::xlen-1:0]         i_wdata,
  output logic [id_pkg::xlen-1:0]         o_rdata1,
  output logic [id_pkg::xlen-1:0]         o_rdata2
);

  import id_pkg::*;

  logic [xlen-1:0] regs [1:31]; // no storage for x0

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // no write-through, new value visible next cycle
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

// File: hw/inst_decoder.sv
// instruction decoder: register indices, immediate and alu/mem/wb controls
`default_nettype none

module inst_decoder (
  input  id_pkg::inst_u                       i_inst,
  output logic [id_pkg::gpr_addr_wd-1:0]      o_rs1,
  output logic [id_pkg::gpr_addr_wd-1:0]      o_rs2,
  output logic [id_pkg::gpr_addr_wd-1:0]      o_rd,
  output logic                                o_rs1_used,
  output logic                                o_rs2_used,
  output logic [id_pkg::xlen-1:0]             o_imm,
  output id_pkg::alu_op_e                     o_alu_op,
  output logic                                o_alu_src1_pc,
  output id_pkg::alu_src2_e                   o_alu_src2_sel,
  output logic                                o_alu_word,
  output id_pkg::br_op_e                      o_br_op,
  output logic                                o_gpr_wen,
  output logic                                o_mem_ren,
  output logic                                o_mem_wen,
  output logic [2:0]                          o_mem_op,
  output logic                                o_invalid_inst
);

  import id_pkg::*;

  logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [2:0]      f3;
  logic [6:0]      f7;
  logic            sr_alt; // funct7 bit picks sra over srl, sub over add

  function automatic alu_op_e alu_of(input logic [2:0] fn3, input logic alt);
    case (fn3)
      f3_add:  alu_of = alt ? alu_sub : alu_add;
      f3_sll:  alu_of = alu_sll;
      f3_slt:  alu_of = alu_slt;
      f3_sltu: alu_of = alu_sltu;
      f3_xor:  alu_of = alu_xor;
      f3_sr:   alu_of = alt ? alu_sra : alu_srl;
      f3_or:   alu_of = alu_or;
      default: alu_of = alu_and;
    endcase
  endfunction

  assign f3     = i_inst.r.funct3;
  assign f7     = i_inst.r.funct7;
  assign sr_alt = f7[5];

  assign imm_i = {{(xlen-12){i_inst.i.imm_11_0[11]}}, i_inst.i.imm_11_0};
  assign imm_s = {{(xlen-12){i_inst.s.imm_11_5[6]}}, i_inst.s.imm_11_5, i_inst.s.imm_4_0};
  assign imm_b = {{(xlen-13){i_inst.b.imm_12}}, i_inst.b.imm_12, i_inst.b.imm_11,
                  i_inst.b.imm_10_5, i_inst.b.imm_4_1, 1'b0};
  assign imm_u = {{(xlen-32){i_inst.u.imm_31_12[19]}}, i_inst.u.imm_31_12, 12'b0};
  assign imm_j = {{(xlen-21){i_inst.j.imm_20}}, i_inst.j.imm_20, i_inst.j.imm_19_12,
                  i_inst.j.imm_11, i_inst.j.imm_10_1, 1'b0};

  // register fields sit at the same bits in every format
  assign o_rs1    = i_inst.r.rs1;
  assign o_rs2    = i_inst.r.rs2;
  assign o_rd     = i_inst.r.rd;
  assign o_mem_op = f3;

  always_comb begin
    o_rs1_used     = 1'b0;
    o_rs2_used     = 1'b0;
    o_imm          = '0;
    o_alu_op       = alu_add;
    o_alu_src1_pc  = 1'b0;
    o_alu_src2_sel = src2_rs2;
    o_alu_word     = 1'b0;
    o_br_op        = br_none;
    o_gpr_wen      = 1'b0;
    o_mem_ren      = 1'b0;
    o_mem_wen      = 1'b0;
    o_invalid_inst = 1'b0;

    case (i_inst.r.opcode)
      opc_op, opc_op_32: begin
        o_rs1_used     = 1'b1;
        o_rs2_used     = 1'b1;
        o_gpr_wen      = 1'b1;
        o_alu_word     = (i_inst.r.opcode == opc_op_32);
        o_alu_op       = alu_of(f3, sr_alt);
        o_invalid_inst = !(f7 == f7_base || (f7 == f7_alt && (f3 == f3_add || f3 == f3_sr)))
                         || (o_alu_word && !(f3 == f3_add || f3 == f3_sll || f3 == f3_sr));
      end
      opc_op_imm: begin
        o_rs1_used     = 1'b1;
        o_gpr_wen      = 1'b1;
        o_imm          = imm_i;
        o_alu_src2_sel = src2_imm;
        o_alu_op       = alu_of(f3, (f3 == f3_sr) && sr_alt);
        // 6-bit shamt, upper bits must be clear
        o_invalid_inst = (f3 == f3_sll && f7[6:1] != 6'b0)
                         || (f3 == f3_sr && {f7[6], f7[4:1]} != 5'b0);
      end
      opc_op_imm_32: begin
        o_rs1_used     = 1'b1;
        o_gpr_wen      = 1'b1;
        o_alu_word     = 1'b1;
        o_imm          = imm_i;
        o_alu_src2_sel = src2_imm;
        o_alu_op       = alu_of(f3, (f3 == f3_sr) && sr_alt);
        o_invalid_inst = !(f3 == f3_add || f3 == f3_sll || f3 == f3_sr)
                         || (f3 == f3_sll && f7 != f7_base)
                         || (f3 == f3_sr && f7 != f7_base && f7 != f7_alt);
      end
      opc_load: begin
        o_rs1_used     = 1'b1;
        o_gpr_wen      = 1'b1;
        o_mem_ren      = 1'b1;
        o_imm          = imm_i;
        o_alu_src2_sel = src2_imm;
        o_invalid_inst = (f3 == 3'b111); // no ldu
      end
      opc_store: begin
        o_rs1_used     = 1'b1;
        o_rs2_used     = 1'b1;
        o_mem_wen      = 1'b1;
        o_imm          = imm_s;
        o_alu_src2_sel = src2_imm;
        o_invalid_inst = f3[2];
      end
      opc_branch: begin
        o_rs1_used = 1'b1;
        o_rs2_used = 1'b1;
        o_imm      = imm_b;
        case (f3)
          f3_beq:  o_br_op = br_eq;
          f3_bne:  o_br_op = br_ne;
          f3_blt:  o_br_op = br_lt;
          f3_bge:  o_br_op = br_ge;
          f3_bltu: o_br_op = br_ltu;
          f3_bgeu: o_br_op = br_geu;
          default: o_invalid_inst = 1'b1;
        endcase
      end
      opc_jal, opc_jalr: begin
        o_rs1_used     = (i_inst.r.opcode == opc_jalr);
        o_imm          = (i_inst.r.opcode == opc_jalr) ? imm_i : imm_j;
        o_br_op        = br_jump;
        o_gpr_wen      = 1'b1;
        o_alu_src1_pc  = 1'b1; // link value is pc + 4 in execute
        o_invalid_inst = (i_inst.r.opcode == opc_jalr) && (f3 != 3'b000);
      end
      opc_lui: begin
        o_gpr_wen      = 1'b1;
        o_imm          = imm_u;
        o_alu_src2_sel = src2_imm;
        o_alu_op       = alu_pass_b;
      end
      opc_auipc: begin
        o_gpr_wen      = 1'b1;
        o_imm          = imm_u;
        o_alu_src1_pc  = 1'b1;
        o_alu_src2_sel = src2_imm;
      end
      default: o_invalid_inst = 1'b1;
    endcase

    if (o_invalid_inst) begin
      o_gpr_wen = 1'b0;
      o_mem_wen = 1'b0;
      o_br_op   = br_none;
    end
    if (o_rd == '0) o_gpr_wen = 1'b0; // x0 never written
  end

endmodule

`default_nettype wire

// File: hw/id_pkg.sv
// id stage package: widths, RV64I opcodes, decode enums and instruction formats
`default_nettype none

package id_pkg;

  localparam int xlen        = 64;
  localparam int inst_wd     = 32;
  localparam int gpr_addr_wd = 5;
  localparam int num_pend    = 3; // es, ms, ws

  // major opcodes
  localparam logic [6:0] opc_op        = 7'b0110011;
  localparam logic [6:0] opc_op_imm    = 7'b0010011;
  localparam logic [6:0] opc_op_32     = 7'b0111011;
  localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
  localparam logic [6:0] opc_load      = 7'b0000011;
  localparam logic [6:0] opc_store     = 7'b0100011;
  localparam logic [6:0] opc_branch    = 7'b1100011;
  localparam logic [6:0] opc_jal       = 7'b1101111;
  localparam logic [6:0] opc_jalr      = 7'b1100111;
  localparam logic [6:0] opc_lui       = 7'b0110111;
  localparam logic [6:0] opc_auipc     = 7'b0010111;

  // alu funct3
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101; // srl / sra
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // branch funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000; // sub, sra

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  typedef enum logic [2:0] {
    br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_jump
  } br_op_e;

  typedef enum logic {
    src2_rs2, src2_imm
  } alu_src2_e;

  // one instruction word, six views
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } inst_u;

endpackage

`default_nettype wire
